// ==== logic/router_pkg.sv ====
`default_nettype none

package router_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int SIZE_W  = 3;
    localparam int TRANS_W = 2;
    localparam int WBEN_W  = 4;

    // Only NONSEQ starts a transfer, everything else is idle
    localparam logic [TRANS_W-1:0] HTRANS_NONSEQ = 2'b10;

    localparam logic [SIZE_W-1:0] SIZE_BYTE = 3'b000;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 3'b001;

    ////////////////////
    // Address map
    ////////////////////
    localparam int REG_SEL_BIT = 15;
    localparam int RAM_SEL_BIT = 14;
    localparam int MEM_ADDR_W  = 12;
    localparam int REG_ADDR_W  = 4;

    typedef enum logic [1:0] {
        TGT_INST,
        TGT_DATA,
        TGT_REG,
        TGT_NONE
    } target_sel_t;

    typedef enum logic {
        MST_IMEM,
        MST_DMEM
    } master_t;

    // Per-target command from the access controller
    typedef struct packed {
        logic    capture;
        master_t src;
        logic    commit;
    } target_cmd_t;

endpackage

`default_nettype wire

// ==== logic/bus_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One master's address phase plus its write data
interface bus_req_if;

    logic                              valid;
    router_pkg::target_sel_t           target;
    logic [router_pkg::ADDR_W-1:0]     addr;
    logic                              write;
    logic [router_pkg::SIZE_W-1:0]     size;
    logic [router_pkg::DATA_W-1:0]     wdata;

    modport src (
        output valid, target, addr, write, size, wdata
    );

    // Arbiter only needs to know who wants what
    modport ctl (
        input valid, target, write
    );

    modport tgt (
        input addr, write, size, wdata
    );

endinterface

`default_nettype wire

// ==== logic/master_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module master_port (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic [router_pkg::ADDR_W-1:0]     haddr,
    input  wire logic                              hwrite,
    input  wire logic [router_pkg::SIZE_W-1:0]     hsize,
    input  wire logic [router_pkg::TRANS_W-1:0]    htrans,
    input  wire logic [router_pkg::DATA_W-1:0]     hwdata,
    input  wire logic                              grant,
    input  wire logic                              hready,
    input  wire logic [router_pkg::DATA_W-1:0]     inst_read,
    input  wire logic [router_pkg::DATA_W-1:0]     data_read,
    input  wire logic [router_pkg::DATA_W-1:0]     reg_read,
    output logic      [router_pkg::DATA_W-1:0]     hrdata,
    bus_req_if.src                                 req
);

    router_pkg::target_sel_t target;
    router_pkg::target_sel_t rd_target;
    logic                    valid;

    ////////////////////
    // Address decode
    ////////////////////
    always_comb begin
        if (htrans != router_pkg::HTRANS_NONSEQ) begin
            target = router_pkg::TGT_NONE;
        end else if (haddr[router_pkg::REG_SEL_BIT]) begin
            target = router_pkg::TGT_REG;
        end else if (haddr[router_pkg::RAM_SEL_BIT]) begin
            target = router_pkg::TGT_DATA;
        end else begin
            target = router_pkg::TGT_INST;
        end
    end

    assign valid      = (target != router_pkg::TGT_NONE);
    assign req.valid  = valid;
    assign req.target = target;
    assign req.addr   = haddr;
    assign req.write  = hwrite;
    assign req.size   = hsize;
    assign req.wdata  = hwdata;

    ////////////////////
    // Data phase
    ////////////////////
    // Held through stalls so hrdata keeps pointing at the right target
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_target <= router_pkg::TGT_NONE;
        end else if (hready) begin
            rd_target <= (valid && grant && !hwrite) ? target : router_pkg::TGT_NONE;
        end
    end

    always_comb begin
        case (rd_target)
            router_pkg::TGT_INST: hrdata = inst_read;
            router_pkg::TGT_DATA: hrdata = data_read;
            router_pkg::TGT_REG:  hrdata = reg_read;
            default:              hrdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/access_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_control (
    input  wire logic               clk,
    input  wire logic               reset,
    bus_req_if.ctl                  imem_req,
    bus_req_if.ctl                  dmem_req,
    output router_pkg::target_cmd_t inst_cmd,
    output router_pkg::target_cmd_t data_cmd,
    output router_pkg::target_cmd_t reg_cmd,
    output logic                    imem_grant,
    output logic                    dmem_grant,
    output logic                    imem_hready,
    output logic                    dmem_hready
);

    localparam int NUM_TGT = 3;

    logic [NUM_TGT-1:0]      pend;
    router_pkg::master_t     favor [NUM_TGT];
    router_pkg::target_cmd_t cmd [NUM_TGT];
    router_pkg::master_t     shared_favor;
    logic                    same;
    logic                    stall;
    logic                    imem_acc;
    logic                    dmem_acc;

    ////////////////////
    // Arbitration
    ////////////////////
    assign same = imem_req.valid && dmem_req.valid && (imem_req.target == dmem_req.target);

    // Favor bit of the target both masters are after
    always_comb begin
        shared_favor = router_pkg::MST_IMEM;
        for (int t = 0; t < NUM_TGT; t++) begin
            if (imem_req.target == router_pkg::target_sel_t'(t)) begin
                shared_favor = favor[t];
            end
        end
    end

    assign imem_grant = !(same && shared_favor == router_pkg::MST_DMEM);
    assign dmem_grant = !(same && shared_favor == router_pkg::MST_IMEM);

    // A committing write holds off both masters for one cycle
    assign stall       = |pend;
    assign imem_hready = imem_grant && !stall;
    assign dmem_hready = dmem_grant && !stall;

    assign imem_acc = imem_req.valid && imem_hready;
    assign dmem_acc = dmem_req.valid && dmem_hready;

    ////////////////////
    // Per-target state
    ////////////////////
    for (genvar t = 0; t < NUM_TGT; t++) begin : g_tgt
        localparam router_pkg::target_sel_t TGT = router_pkg::target_sel_t'(t);
        localparam router_pkg::master_t FAVOR_INIT =
            (TGT == router_pkg::TGT_INST) ? router_pkg::MST_IMEM : router_pkg::MST_DMEM;

        logic                imem_want;
        logic                dmem_want;
        logic                imem_hit;
        logic                dmem_hit;
        logic                pend_q;
        router_pkg::master_t src_q;
        router_pkg::master_t favor_q;

        assign imem_want = imem_req.valid && (imem_req.target == TGT);
        assign dmem_want = dmem_req.valid && (dmem_req.target == TGT);
        assign imem_hit  = imem_acc && imem_want;
        assign dmem_hit  = dmem_acc && dmem_want;

        always_ff @(posedge clk) begin
            if (reset) begin
                pend_q  <= 1'b0;
                favor_q <= FAVOR_INIT;
            end else begin
                pend_q <= (imem_hit && imem_req.write) || (dmem_hit && dmem_req.write);
                if (imem_want && dmem_want && !stall) begin
                    favor_q <= (favor_q == router_pkg::MST_IMEM) ?
                        router_pkg::MST_DMEM : router_pkg::MST_IMEM;
                end
            end
        end

        // Who owns the write data on the next edge
        always_ff @(posedge clk) begin
            if (imem_hit || dmem_hit) begin
                src_q <= dmem_hit ? router_pkg::MST_DMEM : router_pkg::MST_IMEM;
            end
        end

        assign pend[t]  = pend_q;
        assign favor[t] = favor_q;
        assign cmd[t]   = '{
            capture: imem_hit || dmem_hit,
            src:     pend_q ? src_q : (dmem_hit ? router_pkg::MST_DMEM : router_pkg::MST_IMEM),
            commit:  pend_q
        };
    end

    assign inst_cmd = cmd[router_pkg::TGT_INST];
    assign data_cmd = cmd[router_pkg::TGT_DATA];
    assign reg_cmd  = cmd[router_pkg::TGT_REG];

endmodule

`default_nettype wire

// ==== logic/target_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_port #(
    parameter type addr_t = logic [router_pkg::MEM_ADDR_W-1:0]
) (
    input  wire logic                              clk,
    input  wire logic                              reset,
    bus_req_if.tgt                                 imem_req,
    bus_req_if.tgt                                 dmem_req,
    input  wire router_pkg::target_cmd_t           cmd,
    output logic      [router_pkg::DATA_W-1:0]     write,
    output addr_t                                  addr,
    output logic      [router_pkg::WBEN_W-1:0]     wben,
    output logic                                   rwn
);

    localparam int AW = $bits(addr_t);
    // Register block takes byte address bits, the RAMs take word address bits
    localparam int LSB = (AW == router_pkg::REG_ADDR_W) ? 0 : 2;

    logic [router_pkg::ADDR_W-1:0] sel_addr;
    logic [router_pkg::SIZE_W-1:0] sel_size;
    logic                          sel_write;
    logic [router_pkg::DATA_W-1:0] sel_wdata;
    logic [1:0]                    lane_q;
    logic [router_pkg::SIZE_W-1:0] size_q;
    logic                          write_q;
    logic [router_pkg::WBEN_W-1:0] lanes;

    function automatic logic [router_pkg::WBEN_W-1:0] lane_mask(
        input logic [router_pkg::SIZE_W-1:0] size,
        input logic [1:0]                    offset
    );
        logic [router_pkg::WBEN_W-1:0] mask;
        case (size)
            router_pkg::SIZE_BYTE: mask = 4'b0001 << offset;
            router_pkg::SIZE_HALF: mask = offset[1] ? 4'b1100 : 4'b0011;
            default:               mask = 4'b1111;
        endcase
        return mask;
    endfunction

    // cmd.src names the master for both capture and commit
    assign sel_addr  = (cmd.src == router_pkg::MST_DMEM) ? dmem_req.addr  : imem_req.addr;
    assign sel_size  = (cmd.src == router_pkg::MST_DMEM) ? dmem_req.size  : imem_req.size;
    assign sel_write = (cmd.src == router_pkg::MST_DMEM) ? dmem_req.write : imem_req.write;
    assign sel_wdata = (cmd.src == router_pkg::MST_DMEM) ? dmem_req.wdata : imem_req.wdata;

    assign lanes = lane_mask(size_q, lane_q);

    ////////////////////
    // Address phase
    ////////////////////
    always_ff @(posedge clk) begin
        if (cmd.capture) begin
            addr    <= addr_t'(sel_addr[LSB +: AW]);
            lane_q  <= sel_addr[1:0];
            size_q  <= sel_size;
            write_q <= sel_write;
        end
    end

    ////////////////////
    // Write strobe
    ////////////////////
    // rwn drops for one cycle only
    always_ff @(posedge clk) begin
        if (reset) begin
            rwn  <= 1'b1;
            wben <= '0;
        end else begin
            rwn  <= !(cmd.commit && write_q);
            wben <= (cmd.commit && write_q) ? lanes : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.commit) begin
            write <= sel_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/bus_router_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_router_top #(
    parameter int MEM_ADDR_W = router_pkg::MEM_ADDR_W
) (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    // Instruction port of the core
    input  wire logic [router_pkg::ADDR_W-1:0]         imem_haddr,
    input  wire logic                                  imem_hwrite,
    input  wire logic [router_pkg::SIZE_W-1:0]         imem_hsize,
    input  wire logic [router_pkg::TRANS_W-1:0]        imem_htrans,
    input  wire logic [router_pkg::DATA_W-1:0]         imem_hwdata,
    output logic      [router_pkg::DATA_W-1:0]         imem_hrdata,
    output logic                                       imem_hready,
    // Data port of the core
    input  wire logic [router_pkg::ADDR_W-1:0]         dmem_haddr,
    input  wire logic                                  dmem_hwrite,
    input  wire logic [router_pkg::SIZE_W-1:0]         dmem_hsize,
    input  wire logic [router_pkg::TRANS_W-1:0]        dmem_htrans,
    input  wire logic [router_pkg::DATA_W-1:0]         dmem_hwdata,
    output logic      [router_pkg::DATA_W-1:0]         dmem_hrdata,
    output logic                                       dmem_hready,
    // Instruction RAM
    input  wire logic [router_pkg::DATA_W-1:0]         inst_read,
    output logic      [router_pkg::DATA_W-1:0]         inst_write,
    output logic      [MEM_ADDR_W-1:0]                 inst_addr,
    output logic      [router_pkg::WBEN_W-1:0]         inst_wben,
    output logic                                       inst_rwn,
    // Data RAM
    input  wire logic [router_pkg::DATA_W-1:0]         data_read,
    output logic      [router_pkg::DATA_W-1:0]         data_write,
    output logic      [MEM_ADDR_W-1:0]                 data_addr,
    output logic      [router_pkg::WBEN_W-1:0]         data_wben,
    output logic                                       data_rwn,
    // Register block
    input  wire logic [router_pkg::DATA_W-1:0]         reg_read,
    output logic      [router_pkg::DATA_W-1:0]         reg_write,
    output logic      [router_pkg::REG_ADDR_W-1:0]     reg_addr,
    output logic      [router_pkg::WBEN_W-1:0]         reg_wben,
    output logic                                       reg_rwn
);

    router_pkg::target_cmd_t inst_cmd;
    router_pkg::target_cmd_t data_cmd;
    router_pkg::target_cmd_t reg_cmd;
    logic                    imem_grant;
    logic                    dmem_grant;

    bus_req_if imem_bus ();
    bus_req_if dmem_bus ();

    ////////////////////
    // Masters
    ////////////////////
    master_port u_imem_port (
        .clk(clk), .reset(reset),
        .haddr(imem_haddr), .hwrite(imem_hwrite), .hsize(imem_hsize),
        .htrans(imem_htrans), .hwdata(imem_hwdata),
        .grant(imem_grant), .hready(imem_hready),
        .inst_read(inst_read), .data_read(data_read), .reg_read(reg_read),
        .hrdata(imem_hrdata), .req(imem_bus)
    );

    master_port u_dmem_port (
        .clk(clk), .reset(reset),
        .haddr(dmem_haddr), .hwrite(dmem_hwrite), .hsize(dmem_hsize),
        .htrans(dmem_htrans), .hwdata(dmem_hwdata),
        .grant(dmem_grant), .hready(dmem_hready),
        .inst_read(inst_read), .data_read(data_read), .reg_read(reg_read),
        .hrdata(dmem_hrdata), .req(dmem_bus)
    );

    access_control u_ctrl (
        .clk(clk), .reset(reset),
        .imem_req(imem_bus), .dmem_req(dmem_bus),
        .inst_cmd(inst_cmd), .data_cmd(data_cmd), .reg_cmd(reg_cmd),
        .imem_grant(imem_grant), .dmem_grant(dmem_grant),
        .imem_hready(imem_hready), .dmem_hready(dmem_hready)
    );

    ////////////////////
    // Targets
    ////////////////////
    target_port #(.addr_t(logic [MEM_ADDR_W-1:0])) u_inst_port (
        .clk(clk), .reset(reset), .imem_req(imem_bus), .dmem_req(dmem_bus),
        .cmd(inst_cmd), .write(inst_write), .addr(inst_addr),
        .wben(inst_wben), .rwn(inst_rwn)
    );

    target_port #(.addr_t(logic [MEM_ADDR_W-1:0])) u_data_port (
        .clk(clk), .reset(reset), .imem_req(imem_bus), .dmem_req(dmem_bus),
        .cmd(data_cmd), .write(data_write), .addr(data_addr),
        .wben(data_wben), .rwn(data_rwn)
    );

    target_port #(.addr_t(logic [router_pkg::REG_ADDR_W-1:0])) u_reg_port (
        .clk(clk), .reset(reset), .imem_req(imem_bus), .dmem_req(dmem_bus),
        .cmd(reg_cmd), .write(reg_write), .addr(reg_addr),
        .wben(reg_wben), .rwn(reg_rwn)
    );

endmodule

`default_nettype wire

// ==== dv/bus_router_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_router_assert (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic [31:0] imem_haddr,
    input wire logic        imem_hwrite,
    input wire logic [2:0]  imem_hsize,
    input wire logic [1:0]  imem_htrans,
    input wire logic [31:0] imem_hwdata,
    input wire logic [31:0] imem_hrdata,
    input wire logic        imem_hready,
    input wire logic [31:0] dmem_haddr,
    input wire logic        dmem_hwrite,
    input wire logic [2:0]  dmem_hsize,
    input wire logic [1:0]  dmem_htrans,
    input wire logic [31:0] dmem_hwdata,
    input wire logic [31:0] dmem_hrdata,
    input wire logic        dmem_hready,
    input wire logic [31:0] inst_write,
    input wire logic [11:0] inst_addr,
    input wire logic [3:0]  inst_wben,
    input wire logic        inst_rwn,
    input wire logic [31:0] data_write,
    input wire logic [11:0] data_addr,
    input wire logic [3:0]  data_wben,
    input wire logic        data_rwn,
    input wire logic [31:0] reg_write,
    input wire logic [3:0]  reg_addr,
    input wire logic [3:0]  reg_wben,
    input wire logic        reg_rwn
);

    logic        imem_on;
    logic        dmem_on;
    logic        imem_acc;
    logic        dmem_acc;
    logic        same_tgt;
    logic        stall_q;
    logic [2:0]  favor_q;
    logic [1:0]  imem_tgt;
    logic [1:0]  dmem_tgt;
    int unsigned fail_count = 0;

    // 0 instruction RAM, 1 data RAM, 2 registers
    function automatic logic [1:0] decode(input logic [31:0] a);
        return a[15] ? 2'd2 : (a[14] ? 2'd1 : 2'd0);
    endfunction

    function automatic logic [11:0] slice(input logic [31:0] a);
        return a[15] ? {8'h00, a[3:0]} : a[13:2];
    endfunction

    function automatic logic [3:0] lanes(input logic [2:0] s, input logic [1:0] off);
        logic [3:0] m;
        if (s == 3'd0) begin
            m = 4'b0001 << off;
        end else if (s == 3'd1) begin
            m = off[1] ? 4'b1100 : 4'b0011;
        end else begin
            m = 4'b1111;
        end
        return m;
    endfunction

    // Read model: target id in the top byte, registered address below
    function automatic logic [31:0] model(input logic [31:0] a);
        logic [7:0] id;
        id = 8'hA1 + {6'd0, decode(a)};
        return {id, 12'h000, slice(a)};
    endfunction

    assign imem_on  = (imem_htrans == 2'b10);
    assign dmem_on  = (dmem_htrans == 2'b10);
    assign imem_acc = imem_on && imem_hready;
    assign dmem_acc = dmem_on && dmem_hready;
    assign imem_tgt = decode(imem_haddr);
    assign dmem_tgt = decode(dmem_haddr);
    assign same_tgt = imem_on && dmem_on && (imem_tgt == dmem_tgt);

    ////////////////////
    // Stall and favor tracking
    ////////////////////
    // favor bit 1 means dmem wins next
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_q <= 1'b0;
            favor_q <= 3'b110;
        end else begin
            stall_q <= (imem_acc && imem_hwrite) || (dmem_acc && dmem_hwrite);
            if (same_tgt && !stall_q) begin
                favor_q[imem_tgt] <= !favor_q[imem_tgt];
            end
        end
    end

    property write_seq(logic acc, logic [31:0] ha, logic [2:0] hs, logic [31:0] hw,
                       logic [1:0] want, logic trwn, logic [11:0] ta,
                       logic [3:0] tw, logic [31:0] td);
        @(posedge clk) disable iff (reset)
        acc && decode(ha) == want |=> (!imem_hready && !dmem_hready)
            ##1 (!trwn && ta == $past(slice(ha), 2)
                 && tw == $past(lanes(hs, ha[1:0]), 2) && td == $past(hw))
            ##1 (trwn && tw == 4'd0);
    endproperty

    ////////////////////
    // Checks
    ////////////////////
    a_reset: assert property (@(posedge clk) $past(reset) && !reset |->
        inst_rwn && data_rwn && reg_rwn && inst_wben == 4'd0 && data_wben == 4'd0
        && reg_wben == 4'd0 && imem_hready && dmem_hready)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

    a_wr_ii: assert property (write_seq(imem_acc && imem_hwrite, imem_haddr, imem_hsize,
        imem_hwdata, 2'd0, inst_rwn, inst_addr, inst_wben, inst_write))
        else begin
            fail_count++;
            $error("imem write to instruction RAM not strobed as decoded");
        end
    a_wr_id: assert property (write_seq(imem_acc && imem_hwrite, imem_haddr, imem_hsize,
        imem_hwdata, 2'd1, data_rwn, data_addr, data_wben, data_write))
        else begin
            fail_count++;
            $error("imem write to data RAM not strobed as decoded");
        end
    a_wr_ir: assert property (write_seq(imem_acc && imem_hwrite, imem_haddr, imem_hsize,
        imem_hwdata, 2'd2, reg_rwn, {8'h00, reg_addr}, reg_wben, reg_write))
        else begin
            fail_count++;
            $error("imem write to registers not strobed as decoded");
        end
    a_wr_di: assert property (write_seq(dmem_acc && dmem_hwrite, dmem_haddr, dmem_hsize,
        dmem_hwdata, 2'd0, inst_rwn, inst_addr, inst_wben, inst_write))
        else begin
            fail_count++;
            $error("dmem write to instruction RAM not strobed as decoded");
        end
    a_wr_dd: assert property (write_seq(dmem_acc && dmem_hwrite, dmem_haddr, dmem_hsize,
        dmem_hwdata, 2'd1, data_rwn, data_addr, data_wben, data_write))
        else begin
            fail_count++;
            $error("dmem write to data RAM not strobed as decoded");
        end
    a_wr_dr: assert property (write_seq(dmem_acc && dmem_hwrite, dmem_haddr, dmem_hsize,
        dmem_hwdata, 2'd2, reg_rwn, {8'h00, reg_addr}, reg_wben, reg_write))
        else begin
            fail_count++;
            $error("dmem write to registers not strobed as decoded");
        end

    a_rd_imem: assert property (@(posedge clk) disable iff (reset)
        imem_acc && !imem_hwrite |=> imem_hrdata == $past(model(imem_haddr)))
        else begin
            fail_count++;
            $error("imem_hrdata does not match the read model");
        end
    a_rd_dmem: assert property (@(posedge clk) disable iff (reset)
        dmem_acc && !dmem_hwrite |=> dmem_hrdata == $past(model(dmem_haddr)))
        else begin
            fail_count++;
            $error("dmem_hrdata does not match the read model");
        end

    a_contend: assert property (@(posedge clk) disable iff (reset)
        same_tgt && !stall_q |->
        (imem_hready != dmem_hready) && (dmem_hready == favor_q[imem_tgt]))
        else begin
            fail_count++;
            $error("contention not won by the favored master");
        end

    a_parallel: assert property (@(posedge clk) disable iff (reset)
        imem_on && dmem_on && !same_tgt && !stall_q |-> imem_hready && dmem_hready)
        else begin
            fail_count++;
            $error("parallel requests not both accepted");
        end

endmodule

`default_nettype wire

// ==== dv/bus_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_router_tb;

    localparam int TIMEOUT = 20;

    logic        clk;
    logic        reset;
    logic [31:0] imem_haddr;
    logic        imem_hwrite;
    logic [2:0]  imem_hsize;
    logic [1:0]  imem_htrans;
    logic [31:0] imem_hwdata;
    logic [31:0] imem_hrdata;
    logic        imem_hready;
    logic [31:0] dmem_haddr;
    logic        dmem_hwrite;
    logic [2:0]  dmem_hsize;
    logic [1:0]  dmem_htrans;
    logic [31:0] dmem_hwdata;
    logic [31:0] dmem_hrdata;
    logic        dmem_hready;
    logic [31:0] inst_read;
    logic [31:0] inst_write;
    logic [11:0] inst_addr;
    logic [3:0]  inst_wben;
    logic        inst_rwn;
    logic [31:0] data_read;
    logic [31:0] data_write;
    logic [11:0] data_addr;
    logic [3:0]  data_wben;
    logic        data_rwn;
    logic [31:0] reg_read;
    logic [31:0] reg_write;
    logic [3:0]  reg_addr;
    logic [3:0]  reg_wben;
    logic        reg_rwn;
    int unsigned seed_init;

    bus_router_top dut (.*);

    bind bus_router_top bus_router_assert u_assert (.*);

    // Target read models
    assign inst_read = {8'hA1, 12'h000, inst_addr};
    assign data_read = {8'hA2, 12'h000, data_addr};
    assign reg_read  = {8'hA3, 20'h00000, reg_addr};

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (dut.u_assert.fail_count != 0) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure in bus_router_assert");
        end
    end

    function automatic logic [31:0] rand_addr(input int tgt);
        logic [31:0] r;
        r = $urandom;
        if (tgt == 2) begin
            return {16'h0000, 12'h800, r[3:0]};
        end
        return {16'h0000, 1'b0, (tgt == 1), r[13:0]};
    endfunction

    // Address phases on one or both masters, held until each is accepted
    task automatic transfer(input logic i_on, input int i_tgt, input logic i_wr,
                            input logic d_on, input int d_tgt, input logic d_wr);
        logic i_done;
        logic d_done;
        logic i_acc;
        logic d_acc;
        int   cycles;
        i_done = !i_on;
        d_done = !d_on;
        cycles = 0;
        if (i_on) begin
            imem_haddr  = rand_addr(i_tgt);
            imem_hwrite = i_wr;
            imem_hsize  = 3'($urandom_range(0, 2));
            imem_hwdata = $urandom;
            imem_htrans = 2'b10;
        end
        if (d_on) begin
            dmem_haddr  = rand_addr(d_tgt);
            dmem_hwrite = d_wr;
            dmem_hsize  = 3'($urandom_range(0, 2));
            dmem_hwdata = $urandom;
            dmem_htrans = 2'b10;
        end
        while (!(i_done && d_done)) begin
            #1;
            i_acc = !i_done && imem_hready;
            d_acc = !d_done && dmem_hready;
            @(posedge clk);
            #1;
            if (i_acc) begin
                i_done      = 1'b1;
                imem_htrans = 2'b00;
            end
            if (d_acc) begin
                d_done      = 1'b1;
                dmem_htrans = 2'b00;
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout waiting for hready at %0t", $time);
                $display("*** TEST FAILED ***");
                $fatal(1, "hready timeout");
            end
        end
        // Data phase of the last transfer
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed_init   = $urandom(9);
        reset       = 1'b1;
        imem_haddr  = '0;
        imem_hwrite = 1'b0;
        imem_hsize  = 3'd2;
        imem_htrans = 2'b00;
        imem_hwdata = '0;
        dmem_haddr  = '0;
        dmem_hwrite = 1'b0;
        dmem_hsize  = 3'd2;
        dmem_htrans = 2'b00;
        dmem_hwdata = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // SEQ is treated as idle
        imem_htrans = 2'b11;
        repeat (3) @(posedge clk);
        #1;
        imem_htrans = 2'b00;

        ////////////////////
        // Single transfers
        ////////////////////
        for (int t = 0; t < 3; t++) begin
            repeat (3) begin
                transfer(1'b1, t, 1'b1, 1'b0, 0, 1'b0);
                transfer(1'b0, 0, 1'b0, 1'b1, t, 1'b1);
            end
            transfer(1'b1, t, 1'b0, 1'b0, 0, 1'b0);
            transfer(1'b0, 0, 1'b0, 1'b1, t, 1'b0);
        end

        // Contention on each target
        for (int t = 0; t < 3; t++) begin
            repeat (4) transfer(1'b1, t, 1'b0, 1'b1, t, 1'b0);
            repeat (2) transfer(1'b1, t, 1'b1, 1'b1, t, 1'b1);
        end

        // Different targets at once
        for (int t = 0; t < 3; t++) begin
            transfer(1'b1, t, 1'b0, 1'b1, (t + 1) % 3, 1'b0);
            transfer(1'b1, t, 1'b1, 1'b1, (t + 1) % 3, 1'b0);
            transfer(1'b1, t, 1'b1, 1'b1, (t + 2) % 3, 1'b1);
        end

        repeat (4) @(posedge clk);
        #1;
        if (dut.u_assert.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failures in bus_router_assert");
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/router_pkg.sv
logic/bus_req_if.sv
logic/master_port.sv
logic/access_control.sv
logic/target_port.sv
logic/bus_router_top.sv
dv/bus_router_assert.sv
dv/bus_router_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bus_router_tb
RTL_TOP   ?= bus_router_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q '\*\*\* TEST PASSED \*\*\*'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
